// ==== verilog/rcn_pkg.sv ====
// Shared ring word layout, node ids, slave windows and memory timing, imported by every RTL block
package rcn_pkg;

  // Width of one ring word, which moves one node per clock
  localparam int RCN_W = 64;

  // Set when the slot carries a transaction, clear for an empty slot
  localparam int RCN_VALID_BIT = 63;

  // Set for a request and clear for a response
  localparam int RCN_REQ_BIT = 62;

  // Id of the master that issued the request, kept in its response
  localparam int RCN_ID_HI = 61;
  localparam int RCN_ID_LO = 56;

  // Reserved bits stay zero in both requests and responses
  localparam int RCN_RSV_HI = 55;
  localparam int RCN_RSV_LO = 54;

  // Byte mask, where zero means a read
  localparam int RCN_MASK_HI = 53;
  localparam int RCN_MASK_LO = 50;

  // Word address, the byte address without its two low bits
  localparam int RCN_ADDR_HI = 49;
  localparam int RCN_ADDR_LO = 32;

  // Write data in a request and read data in a response
  localparam int RCN_DATA_HI = 31;
  localparam int RCN_DATA_LO = 0;

  // Master ids; zero is never used, so a cleared header matches no master
  localparam logic [5:0] MASTER0_ID = 6'd1;
  localparam logic [5:0] MASTER1_ID = 6'd2;

  // Byte address windows of the two RAM slaves
  localparam logic [19:0] SLAVE_ADDR_MASK = 20'hF0000;
  localparam logic [19:0] SLAVE0_BASE     = 20'h10000;
  localparam logic [19:0] SLAVE1_BASE     = 20'h20000;

  // Wait cycles added by each memory on every access
  localparam int unsigned SLAVE0_WAIT = 0;
  localparam int unsigned SLAVE1_WAIT = 3;

  // Low word address bits that each memory really stores
  localparam int RAM_DEPTH_LOG2 = 8;

  // Master state codes
  localparam logic [1:0] MST_IDLE   = 2'd0;
  localparam logic [1:0] MST_INJECT = 2'd1;
  localparam logic [1:0] MST_WAIT   = 2'd2;
  localparam logic [1:0] MST_ACK    = 2'd3;

endpackage

// ==== verilog/wait_ram.sv ====
// Byte-maskable 32-bit memory that stretches every access by a fixed number of wait cycles
`timescale 1ns/100ps

module wait_ram
  import rcn_pkg::*;
#(
  parameter int unsigned WAIT_CYCLES = SLAVE0_WAIT
)
(
  input  logic        CLK,
  input  logic        RST,

  input  logic        cs,
  input  logic        we,
  input  logic [19:0] addr,
  input  logic [3:0]  mask,
  input  logic [31:0] wr_data,
  output logic        ram_wait,
  output logic [31:0] rd_data
);

  // Storage for the low word address bits only, higher bits alias
  logic [31:0] mem [2**RAM_DEPTH_LOG2];

  // Word index taken from the byte address
  logic [RAM_DEPTH_LOG2-1:0] idx;

  // Stored word with the write bytes merged in
  logic [31:0] merged;

  // Wait cycles still to go in the current access
  logic [7:0]  wait_cnt;

  assign idx = addr[RAM_DEPTH_LOG2+1:2];

  // The counter idles at its full value, so a new access starts waiting at once
  assign ram_wait = cs && (wait_cnt != 8'd0);

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      wait_cnt <= 8'(WAIT_CYCLES);
    end
    else if (cs)
    begin
      // Count down while waiting, reload in the completing cycle
      if (wait_cnt != 8'd0)
        wait_cnt <= wait_cnt - 8'd1;
      else
        wait_cnt <= 8'(WAIT_CYCLES);
    end
  end

  // Each set mask bit replaces one byte of the stored word
  always_comb
  begin
    merged = mem[idx];
    for (int i = 0; i < 4; i++)
    begin
      if (mask[i])
        merged[8*i +: 8] = wr_data[8*i +: 8];
    end
  end

  // A read has an all-zero mask, so the merged word is the stored word
  assign rd_data = merged;

  // The write lands only in the completing cycle
  always_ff @(posedge CLK)
  begin
    if (cs && we && !ram_wait)
    begin
      mem[idx] <= merged;
    end
  end

endmodule

// ==== verilog/rcn_slave_ram_w.sv ====
// Ring slave node that serves requests in its address window through a RAM port with wait
`timescale 1ns/100ps

module rcn_slave_ram_w
  import rcn_pkg::*;
#(
  parameter logic [19:0] ADDR_BASE = SLAVE0_BASE,
  parameter logic [19:0] ADDR_MASK = SLAVE_ADDR_MASK
)
(
  input  logic             CLK,
  input  logic             RST,

  input  logic [RCN_W-1:0] ring_in,
  output logic [RCN_W-1:0] ring_out,

  output logic             cs,
  input  logic             ram_wait,
  output logic             we,
  output logic [19:0]      addr,
  output logic [3:0]       mask,
  output logic [31:0]      wr_data,
  input  logic [31:0]      rd_data
);

  // Registered ring input, where the claim decision is made
  logic [RCN_W-1:0] din;

  // Request held until the memory completes it
  logic [RCN_W-1:0] din_req;

  // Response held until an empty slot passes
  logic [RCN_W-1:0] din_rsp;

  logic in_window;
  logic busy;
  logic claim;
  logic done;
  logic rsp_out;

  // Compare the byte address of the word with the slave's window
  assign in_window = ({din[RCN_ADDR_HI:RCN_ADDR_LO], 2'b00} & ADDR_MASK) ==
                     (ADDR_BASE & ADDR_MASK);

  // One transaction at a time, a request or its response
  assign busy = din_req[RCN_VALID_BIT] || din_rsp[RCN_VALID_BIT];

  // A busy slave lets the request pass, and it comes round again later
  assign claim = din[RCN_VALID_BIT] && din[RCN_REQ_BIT] && in_window && !busy;

  // The memory finishes in the cycle where the wait is low
  assign done = din_req[RCN_VALID_BIT] && !ram_wait;

  // The response goes out only in an empty slot
  assign rsp_out = din_rsp[RCN_VALID_BIT] && !din[RCN_VALID_BIT];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      din      <= '0;
      din_req  <= '0;
      din_rsp  <= '0;
      ring_out <= '0;
    end
    else
    begin
      din <= ring_in;

      if (claim)
        din_req <= din;
      else if (done)
        din_req <= '0;

      // The response keeps id, mask and address and replaces the data field
      if (done)
        din_rsp <= {1'b1, 1'b0, din_req[RCN_ID_HI:RCN_ADDR_LO], rd_data};
      else if (rsp_out)
        din_rsp <= '0;

      // A claimed slot is emptied, a free slot carries the held response
      if (claim)
        ring_out <= '0;
      else if (rsp_out)
        ring_out <= din_rsp;
      else
        ring_out <= din;
    end
  end

  // RAM port, driven straight from the held request
  assign cs      = din_req[RCN_VALID_BIT];
  assign we      = |din_req[RCN_MASK_HI:RCN_MASK_LO];
  assign addr    = {din_req[RCN_ADDR_HI:RCN_ADDR_LO], 2'b00};
  assign mask    = din_req[RCN_MASK_HI:RCN_MASK_LO];
  assign wr_data = din_req[RCN_DATA_HI:RCN_DATA_LO];

endmodule

// ==== verilog/rcn_master.sv ====
// Ring master node, one per host port of the ring top, that turns a four-phase host transaction into a ring request
`timescale 1ns/100ps

module rcn_master
  import rcn_pkg::*;
#(
  parameter logic [5:0] MASTER_ID = MASTER0_ID
)
(
  input  logic             CLK,
  input  logic             RST,

  input  logic [RCN_W-1:0] ring_in,
  output logic [RCN_W-1:0] ring_out,

  input  logic             host_req,
  input  logic [3:0]       host_mask,
  input  logic [19:0]      host_addr,
  input  logic [31:0]      host_wdata,
  output logic             host_ack,
  output logic [31:0]      host_rdata
);

  // Current phase of the single outstanding transaction
  logic [1:0]       state;

  // Request word kept while the master looks for an empty slot
  logic [RCN_W-1:0] req_word;

  // Request word built straight from the host fields
  logic [RCN_W-1:0] host_word;

  logic             slot_free;
  logic             own_word;
  logic             own_rsp;

  // The host address is a byte address, the ring carries word addresses
  assign host_word = {1'b1, 1'b1, MASTER_ID, 2'b00, host_mask, host_addr[19:2], host_wdata};

  // An empty slot is any word with the valid bit clear
  assign slot_free = !ring_in[RCN_VALID_BIT];

  // A word tagged with this master's id
  assign own_word = ring_in[RCN_ID_HI:RCN_ID_LO] == MASTER_ID;

  // Only a response with our id ends the transaction
  // An own request that comes back was passed by a busy slave and keeps circling
  assign own_rsp = ring_in[RCN_VALID_BIT] && !ring_in[RCN_REQ_BIT] && own_word;

  // The ack follows the state register, so it drops one cycle after host_req falls
  assign host_ack = (state == MST_ACK);

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      state    <= MST_IDLE;
      ring_out <= '0;
    end
    else
    begin
      // By default every word moves on unchanged
      ring_out <= ring_in;

      case (state)
        MST_IDLE:
        begin
          if (host_req)
          begin
            // Use the slot that passes right now if it is empty
            if (slot_free)
            begin
              ring_out <= host_word;
              state    <= MST_WAIT;
            end
            else
            begin
              state <= MST_INJECT;
            end
          end
        end

        MST_INJECT:
        begin
          // Wait for the first empty slot while foreign words keep flowing
          if (slot_free)
          begin
            ring_out <= req_word;
            state    <= MST_WAIT;
          end
        end

        MST_WAIT:
        begin
          // Take our response off the ring and leave an empty slot behind
          if (own_rsp)
          begin
            ring_out <= '0;
            state    <= MST_ACK;
          end
        end

        MST_ACK:
        begin
          // Hold the ack until the host releases its request
          if (!host_req)
          begin
            state <= MST_IDLE;
          end
        end

        default:
        begin
          state <= MST_IDLE;
        end
      endcase
    end
  end

  // Payload registers for the pending request and the returned data
  always_ff @(posedge CLK)
  begin
    // The host fields are stable while host_req is high
    if ((state == MST_IDLE) && host_req)
    begin
      req_word <= host_word;
    end

    // Read data stays unchanged while host_ack is high
    if ((state == MST_WAIT) && own_rsp)
    begin
      host_rdata <= ring_in[RCN_DATA_HI:RCN_DATA_LO];
    end
  end

endmodule

// ==== verilog/rcn_ring_top.sv ====
// Top level that closes two masters and two RAM slaves into one ring with two host ports
`timescale 1ns/100ps

module rcn_ring_top
  import rcn_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  input  logic        host_req_0,
  input  logic [3:0]  host_mask_0,
  input  logic [19:0] host_addr_0,
  input  logic [31:0] host_wdata_0,
  output logic        host_ack_0,
  output logic [31:0] host_rdata_0,

  input  logic        host_req_1,
  input  logic [3:0]  host_mask_1,
  input  logic [19:0] host_addr_1,
  input  logic [31:0] host_wdata_1,
  output logic        host_ack_1,
  output logic [31:0] host_rdata_1
);

  // Ring segments, named after the node that drives each one
  logic [RCN_W-1:0] ring_m0;
  logic [RCN_W-1:0] ring_s0;
  logic [RCN_W-1:0] ring_m1;
  logic [RCN_W-1:0] ring_s1;

  // RAM port of slave 0
  logic        cs_0;
  logic        wait_0;
  logic        we_0;
  logic [19:0] addr_0;
  logic [3:0]  mask_0;
  logic [31:0] wr_data_0;
  logic [31:0] rd_data_0;

  // RAM port of slave 1
  logic        cs_1;
  logic        wait_1;
  logic        we_1;
  logic [19:0] addr_1;
  logic [3:0]  mask_1;
  logic [31:0] wr_data_1;
  logic [31:0] rd_data_1;

  // Ring order is master 0, slave 0, master 1, slave 1 and back
  rcn_master #(.MASTER_ID(MASTER0_ID)) i_master_0 (
    .CLK(CLK), .RST(RST), .ring_in(ring_s1), .ring_out(ring_m0),
    .host_req(host_req_0), .host_mask(host_mask_0), .host_addr(host_addr_0),
    .host_wdata(host_wdata_0), .host_ack(host_ack_0), .host_rdata(host_rdata_0)
  );

  rcn_slave_ram_w #(.ADDR_BASE(SLAVE0_BASE), .ADDR_MASK(SLAVE_ADDR_MASK)) i_slave_0 (
    .CLK(CLK), .RST(RST), .ring_in(ring_m0), .ring_out(ring_s0),
    .cs(cs_0), .ram_wait(wait_0), .we(we_0), .addr(addr_0), .mask(mask_0),
    .wr_data(wr_data_0), .rd_data(rd_data_0)
  );

  rcn_master #(.MASTER_ID(MASTER1_ID)) i_master_1 (
    .CLK(CLK), .RST(RST), .ring_in(ring_s0), .ring_out(ring_m1),
    .host_req(host_req_1), .host_mask(host_mask_1), .host_addr(host_addr_1),
    .host_wdata(host_wdata_1), .host_ack(host_ack_1), .host_rdata(host_rdata_1)
  );

  rcn_slave_ram_w #(.ADDR_BASE(SLAVE1_BASE), .ADDR_MASK(SLAVE_ADDR_MASK)) i_slave_1 (
    .CLK(CLK), .RST(RST), .ring_in(ring_m1), .ring_out(ring_s1),
    .cs(cs_1), .ram_wait(wait_1), .we(we_1), .addr(addr_1), .mask(mask_1),
    .wr_data(wr_data_1), .rd_data(rd_data_1)
  );

  // Slave 0 memory answers at once, slave 1 memory is the slow one
  wait_ram #(.WAIT_CYCLES(SLAVE0_WAIT)) i_ram_0 (
    .CLK(CLK), .RST(RST), .cs(cs_0), .we(we_0), .addr(addr_0), .mask(mask_0),
    .wr_data(wr_data_0), .ram_wait(wait_0), .rd_data(rd_data_0)
  );

  wait_ram #(.WAIT_CYCLES(SLAVE1_WAIT)) i_ram_1 (
    .CLK(CLK), .RST(RST), .cs(cs_1), .we(we_1), .addr(addr_1), .mask(mask_1),
    .wr_data(wr_data_1), .ram_wait(wait_1), .rd_data(rd_data_1)
  );

endmodule

// ==== testbench/tb_clock.sv ====
// Clock and reset source for the ring testbench, instantiated once in the testbench top
`timescale 1ns/100ps

module tb_clock
(
  output logic CLK,
  output logic RST
);

  // 20 ns period, so each half period is 10 ns
  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Reset covers the first two rising edges and drops just after the second
  initial
  begin
    RST = 1'b1;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;
  end

endmodule

// ==== testbench/tb_rcn_ring.sv ====
// Self-checking testbench for the ring memory subsystem, compiled as the simulation top
`timescale 1ns/100ps

module tb_rcn_ring
  import rcn_pkg::*;
();

  localparam int CLK_PERIOD = 20;

  // The run has 32 write and read pairs, 8 partial pairs and 24 per master in parallel
  localparam int N_CONC  = 24;
  localparam int N_TOTAL = 64 + 16 + 2 * N_CONC;

  // Ring round trip with the slave input stage and the handshake, rounded up
  localparam int ROUND_TRIP      = 8;
  localparam int SLOW_WAIT       = SLAVE1_WAIT + 1;
  localparam int ACK_LIMIT       = 4 * ROUND_TRIP * SLOW_WAIT;
  localparam int WATCHDOG_CYCLES = N_TOTAL * ROUND_TRIP * SLOW_WAIT * 2;

  logic             CLK;
  logic             RST;
  logic [1:0]       host_req;
  logic [1:0][3:0]  host_mask;
  logic [1:0][19:0] host_addr;
  logic [1:0][31:0] host_wdata;
  wire  [1:0]       host_ack;
  wire  [1:0][31:0] host_rdata;

  // Expected contents of each slave memory, indexed by the stored word bits
  logic [31:0]      shadow [2][2**RAM_DEPTH_LOG2];
  logic [31:0]      rng_state = 32'd9;

  // Random control and data words for the parallel phase, drawn in a fixed order
  logic [31:0]      conc_ctl   [2][N_CONC];
  logic [31:0]      conc_wdata [2][N_CONC];

  // Port values seen at the previous falling edge
  logic [1:0]       ack_prev = '0;
  logic [1:0]       req_prev = '0;
  logic [1:0][31:0] rdata_prev;

  tb_clock i_tb_clock (.CLK(CLK), .RST(RST));

  rcn_ring_top i_rcn_ring_top (
    .CLK(CLK), .RST(RST),
    .host_req_0(host_req[0]), .host_mask_0(host_mask[0]), .host_addr_0(host_addr[0]),
    .host_wdata_0(host_wdata[0]), .host_ack_0(host_ack[0]), .host_rdata_0(host_rdata[0]),
    .host_req_1(host_req[1]), .host_mask_1(host_mask[1]), .host_addr_1(host_addr[1]),
    .host_wdata_1(host_wdata[1]), .host_ack_1(host_ack[1]), .host_rdata_1(host_rdata[1])
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  // 32-bit xorshift with shifts 13, 17 and 5
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Every set enable bit takes one byte from the new word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  byte_en);
    logic [31:0] bits;
    bits = {{8{byte_en[3]}}, {8{byte_en[2]}}, {8{byte_en[1]}}, {8{byte_en[0]}}};
    return (old_word & ~bits) | (new_word & bits);
  endfunction

  // One four-phase transaction on a host port is checked against the shadow word
  task automatic run_xfer(input int port, input int slv, input int idx,
                          input logic [3:0] wmask, input logic [31:0] wdata);
    logic [31:0] expected;
    logic [31:0] got;
    int          cycles;
    // A read returns the stored word, a write the word after the merge
    expected = merge_bytes(shadow[slv][idx], wdata, wmask);
    cycles   = 0;
    @(posedge CLK);
    #1;
    host_mask[port]  = wmask;
    host_addr[port]  = (slv == 0 ? SLAVE0_BASE : SLAVE1_BASE) | 20'(idx * 4);
    host_wdata[port] = wdata;
    host_req[port]   = 1'b1;
    while (host_ack[port] !== 1'b1)
    begin
      @(posedge CLK);
      #1;
      cycles++;
      if (cycles > ACK_LIMIT)
        stop_run($sformatf("host_ack_%0d did not rise within %0d cycles", port, ACK_LIMIT));
    end
    got = host_rdata[port];
    // Request stays up one more cycle so the ack is seen with it high
    @(posedge CLK);
    #1;
    host_req[port] = 1'b0;
    assert (got === expected)
    else stop_run($sformatf("[FAIL] host_rdata_%0d = %h, expected %h", port, got, expected));
    shadow[slv][idx] = expected;
    while (host_ack[port] !== 1'b0)
    begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic random_traffic(input int port);
    logic [31:0] r;
    int          slv;
    for (int i = 0; i < N_CONC; i++)
    begin
      r   = conc_ctl[port][i];
      // Three in four go to the slow slave, so requests pile up and circle there
      slv = (r[9:8] != 2'b00) ? 1 : 0;
      // Each master keeps to its own words, which fixes the order of shadow updates
      run_xfer(port, slv, {r[2:0], port[0]}, r[7:4], conc_wdata[port][i]);
    end
  endtask

  // Four-phase rules are sampled on the falling edge where every port is stable
  always @(negedge CLK)
  begin
    if (RST === 1'b0)
    begin
      for (int p = 0; p < 2; p++)
      begin
        // The ack may only rise while the request is high
        assert (!host_ack[p] || ack_prev[p] || host_req[p])
        else stop_run($sformatf("host_ack_%0d rose while host_req_%0d was low", p, p));
        // The ack may only fall once the request has already fallen
        assert (host_ack[p] || !ack_prev[p] || !req_prev[p])
        else stop_run($sformatf("host_ack_%0d fell before host_req_%0d was released", p, p));
        // Read data must hold for as long as the ack stays high
        assert (!(host_ack[p] && ack_prev[p]) || host_rdata[p] === rdata_prev[p])
        else stop_run($sformatf("[FAIL] host_rdata_%0d changed from %h to %h during ack",
                                p, rdata_prev[p], host_rdata[p]));
      end
    end
    ack_prev   = host_ack;
    req_prev   = host_req;
    rdata_prev = host_rdata;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_run($sformatf("Watchdog expired after %0d clock cycles", WATCHDOG_CYCLES));
  end

  initial
  begin
    logic [31:0] r;
    logic [3:0]  pmask;
    host_req   = '0;
    host_mask  = '0;
    host_addr  = '0;
    host_wdata = '0;
    wait (RST === 1'b0);
    @(negedge CLK);
    assert (host_ack === 2'b00)
    else stop_run($sformatf("[FAIL] host_ack_0 = %h, host_ack_1 = %h after reset, expected 0",
                            host_ack[0], host_ack[1]));

    // Full-mask write then read from each master to each slave, which fills words 0 to 15
    for (int m = 0; m < 2; m++)
    begin
      for (int s = 0; s < 2; s++)
      begin
        for (int k = 0; k < 8; k++)
        begin
          run_xfer(m, s, m * 8 + k, 4'hF, next_rand());
          run_xfer(m, s, m * 8 + k, 4'h0, 32'h0);
        end
      end
    end

    // Partial writes are each read back afterwards
    for (int k = 0; k < 8; k++)
    begin
      r     = next_rand();
      pmask = (r[3:0] == 4'h0 || r[3:0] == 4'hF) ? 4'b0110 : r[3:0];
      run_xfer(k % 2, k / 4, r[7:4], pmask, next_rand());
      run_xfer(k % 2, k / 4, r[7:4], 4'h0, 32'h0);
    end

    // Both ports take their random words before they start together
    for (int i = 0; i < N_CONC; i++)
    begin
      for (int p = 0; p < 2; p++)
      begin
        conc_ctl[p][i]   = next_rand();
        conc_wdata[p][i] = next_rand();
      end
    end

    // Both masters run at once with reads and writes mixed
    fork
      random_traffic(0);
      random_traffic(1);
    join

    $display("No errors");
    $finish;
  end

endmodule

// ==== list.f ====
verilog/rcn_pkg.sv
verilog/wait_ram.sv
verilog/rcn_slave_ram_w.sv
verilog/rcn_master.sv
verilog/rcn_ring_top.sv
testbench/tb_clock.sv
testbench/tb_rcn_ring.sv

// ==== Bender.yml ====
package:
  name: rcn_ring

sources:
  - files:
      - verilog/rcn_pkg.sv
      - verilog/wait_ram.sv
      - verilog/rcn_slave_ram_w.sv
      - verilog/rcn_master.sv
      - verilog/rcn_ring_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_rcn_ring.sv
